// File: src/vec_data_pkg.sv
package vec_data_pkg;

	localparam int DATA_W    = 32;	// Element width
	localparam int ADDR_W    = 16;	// Address, stride and length width
	localparam int VREG_W    = 2;	// Vector register number width
	localparam int NUM_VREGS = 1 << VREG_W;

	// One vector element or scalar
	typedef logic [DATA_W-1:0] data_t;

	// Memory address; stride and length share the width
	typedef logic [ADDR_W-1:0] address_t;

	// Vector register number
	typedef logic [VREG_W-1:0] vreg_idx_t;

endpackage

// File: src/vec_cmd_pkg.sv
package vec_cmd_pkg;

	// Host command kinds
	typedef enum logic [1:0] {
		OP_FILL  = 2'd0,	// Broadcast scalar into register
		OP_STORE = 2'd1,	// Register to memory
		OP_LOAD  = 2'd2,	// Memory to register
		OP_READ  = 2'd3	// One element back as scalar
	} opcode_e;

	// Command word on the host port; base is the element index for OP_READ
	typedef struct packed {
		opcode_e                opcode;
		vec_data_pkg::vreg_idx_t vreg;
		vec_data_pkg::address_t  base;
		vec_data_pkg::address_t  stride;
		vec_data_pkg::address_t  length;
		vec_data_pkg::data_t     scalar;
	} vec_cmd_t;

	// Strided access description
	typedef struct packed {
		vec_data_pkg::address_t base;
		vec_data_pkg::address_t stride;
		vec_data_pkg::address_t length;
	} mem_cfg_t;

	// LSU request towards memory
	typedef struct packed {
		logic st_req;	// Store access in progress
		logic ld_req;	// Load access in progress
		logic valid;	// Element moves this cycle
	} mem_req_t;

	// Memory ready flags plus end of access from the generator
	typedef struct packed {
		logic st_ready;
		logic ld_ready;
		logic st_end;
		logic ld_end;
	} mem_status_t;

endpackage

// File: src/vec_cmd_decoder.sv
`timescale 1ns/1ns

module vec_cmd_decoder (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    cmd_req,
	input  vec_cmd_pkg::vec_cmd_t   cmd,
	input  logic                    st_done,
	input  logic                    ld_done,
	output logic                    cmd_ack,
	output logic                    st_start,
	output logic                    ld_start,
	output vec_cmd_pkg::mem_cfg_t   cfg,
	output vec_data_pkg::vreg_idx_t vreg,
	output logic                    fill_en,
	output logic                    read_en,
	output vec_data_pkg::data_t     scalar,
	output vec_data_pkg::address_t  elem_idx
);

	typedef enum logic [2:0] {IDLE, ISSUE, WAIT, ACK, RELEASE} state_e;

	state_e                state;
	vec_cmd_pkg::vec_cmd_t cmd_q;	// Held for the whole command
	logic                  is_mem_op;

	assign is_mem_op = (cmd_q.opcode == vec_cmd_pkg::OP_STORE) ||
		(cmd_q.opcode == vec_cmd_pkg::OP_LOAD);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (cmd_req) state <= ISSUE;
				ISSUE:   state <= is_mem_op ? WAIT : ACK;	// Fill and read finish here
				WAIT:    if (st_done || ld_done) state <= ACK;
				ACK:     if (!cmd_req) state <= RELEASE;
				RELEASE: state <= IDLE;	// Ack is already low
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && cmd_req) cmd_q <= cmd;	// Host keeps cmd stable under req
	end

	assign st_start = (state == ISSUE) && (cmd_q.opcode == vec_cmd_pkg::OP_STORE);
	assign ld_start = (state == ISSUE) && (cmd_q.opcode == vec_cmd_pkg::OP_LOAD);
	assign fill_en  = (state == ISSUE) && (cmd_q.opcode == vec_cmd_pkg::OP_FILL);
	assign read_en  = (state == ISSUE) && (cmd_q.opcode == vec_cmd_pkg::OP_READ);
	assign cmd_ack  = (state == ACK);

	assign cfg      = '{base: cmd_q.base, stride: cmd_q.stride, length: cmd_q.length};
	assign vreg     = cmd_q.vreg;
	assign scalar   = cmd_q.scalar;
	assign elem_idx = cmd_q.base;	// Element index for reads

	// Four-phase rule: ack may only drop once the host has released req
	ack_holds_under_req: assert property (
		@(posedge clock) disable iff (reset)
		(cmd_ack && cmd_req) |=> cmd_ack
	);

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     st_start,
	input  logic                     ld_start,
	input  vec_cmd_pkg::mem_cfg_t    cfg,
	input  logic                     stall,
	input  vec_cmd_pkg::mem_status_t status,
	input  vec_data_pkg::data_t      st_data_rf,
	input  vec_data_pkg::data_t      ld_data_mem,
	output vec_cmd_pkg::mem_req_t    req,
	output logic                     run,
	output vec_cmd_pkg::mem_cfg_t    cfg_out,
	output logic                     st_rd_rf,
	output logic                     ld_wr_rf,
	output vec_data_pkg::data_t      st_data,
	output vec_data_pkg::data_t      ld_data,
	output logic                     st_done,
	output logic                     ld_done
);

	logic                  st_active;
	logic                  ld_active;
	logic                  st_move;	// Store element leaves the RF this cycle
	logic                  ld_move;	// Load address issued this cycle
	logic                  st_end_q;
	logic                  ld_wait;	// Last load address issued, pipe draining
	logic [1:0]            ld_pipe;	// Valid bits for memory read and LSU register
	vec_cmd_pkg::mem_cfg_t cfg_q;

	assign st_move = st_active & ~stall & status.st_ready;
	assign ld_move = ld_active & ~stall & status.ld_ready;

	assign req      = '{st_req: st_active, ld_req: ld_active, valid: st_move | ld_move};
	assign cfg_out  = cfg_q;
	assign st_rd_rf = st_move;
	assign ld_wr_rf = ld_pipe[1] & ~stall;	// Two cycles behind the address
	assign st_done  = st_end_q;
	assign ld_done  = ld_wait & ~|ld_pipe;

	always_ff @(posedge clock) begin
		if (reset) begin
			st_active <= 1'b0;
			ld_active <= 1'b0;
			run       <= 1'b0;
		end else begin
			if (status.st_end) st_active <= 1'b0;
			else if (st_start) st_active <= 1'b1;
			if (status.ld_end) ld_active <= 1'b0;
			else if (ld_start) ld_active <= 1'b1;
			// Run covers the drain, so it ends with done
			if (st_done || ld_done) run <= 1'b0;
			else if (st_start || ld_start) run <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			st_end_q <= 1'b0;
			ld_wait  <= 1'b0;
			ld_pipe  <= 2'b00;
		end else begin
			st_end_q <= status.st_end;
			if (status.ld_end) ld_wait <= 1'b1;
			else if (ld_done) ld_wait <= 1'b0;
			if (!stall) ld_pipe <= {ld_pipe[0], ld_move};	// Frozen under stall
		end
	end

	always_ff @(posedge clock) begin
		if ((st_start || ld_start) && !run) cfg_q <= cfg;	// Only taken when idle
	end

	always_ff @(posedge clock) begin
		if (!stall) st_data <= st_data_rf;
		if (run && !stall) ld_data <= ld_data_mem;
	end

	// Only one direction may own the memory port
	single_direction: assert property (
		@(posedge clock) disable iff (reset)
		!(st_active && ld_active)
	);

endmodule

// File: src/stride_addr_gen.sv
`timescale 1ns/1ns

module stride_addr_gen #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   run,
	input  vec_cmd_pkg::mem_cfg_t  cfg,
	input  vec_cmd_pkg::mem_req_t  req,
	input  logic                   advance,
	output vec_data_pkg::address_t addr,
	output logic                   st_end,
	output logic                   ld_end
);

	logic                   run_q;
	logic                   first;	// First cycle of an access
	logic                   last;
	vec_data_pkg::address_t addr_q;
	vec_data_pkg::address_t cnt_q;	// Elements still to issue
	vec_data_pkg::address_t cur_cnt;
	vec_data_pkg::address_t next_addr;

	function automatic vec_data_pkg::address_t wrap(input logic [31:0] a);
		return vec_data_pkg::address_t'(a % MEM_DEPTH);
	endfunction

	assign first = run & ~run_q;

	// Base and length come straight from cfg in the first cycle
	assign addr      = first ? wrap(32'(cfg.base)) : addr_q;
	assign cur_cnt   = first ? cfg.length : cnt_q;
	assign next_addr = wrap(32'(addr) + 32'(cfg.stride));

	// Length 0 behaves like length 1 so the access always ends
	assign last   = advance & (cur_cnt <= 16'd1);
	assign st_end = last & req.st_req;
	assign ld_end = last & req.ld_req;

	always_ff @(posedge clock) begin
		if (reset) begin
			run_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			run_q <= run;
			if (run) cnt_q <= advance ? cur_cnt - 16'd1 : cur_cnt;
		end
	end

	always_ff @(posedge clock) begin
		if (run) addr_q <= advance ? next_addr : addr;	// Hold address under stall
	end

endmodule

// File: src/local_data_mem.sv
`timescale 1ns/1ns

module local_data_mem #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                   clock,
	input  logic                   reset,
	input  vec_data_pkg::address_t addr,
	input  vec_cmd_pkg::mem_req_t  req,
	input  logic                   stall,
	input  vec_data_pkg::data_t    wdata,
	output vec_data_pkg::data_t    rdata,
	output logic                   st_ready,
	output logic                   ld_ready
);

	localparam int AW = $clog2(MEM_DEPTH);

	vec_data_pkg::data_t mem [MEM_DEPTH];
	logic                wr_pend;	// Store issued last cycle
	logic [AW-1:0]       wr_addr;

	assign st_ready = ~stall;
	assign ld_ready = ~stall;

	// Store data arrives from the LSU register one cycle after the address
	always_ff @(posedge clock) begin
		if (reset) wr_pend <= 1'b0;
		else wr_pend <= req.valid & req.st_req & ~stall;
	end

	always_ff @(posedge clock) begin
		wr_addr <= addr[AW-1:0];
		if (wr_pend) mem[wr_addr] <= wdata;
	end

	always_ff @(posedge clock) begin
		if (reset) rdata <= '0;
		else if (req.valid && req.ld_req && !stall) rdata <= mem[addr[AW-1:0]];	// 1-cycle read
	end

endmodule

// File: src/vector_reg_file.sv
`timescale 1ns/1ns

module vector_reg_file #(
	parameter int VLEN = 16
) (
	input  logic                    clock,
	input  logic                    reset,
	input  vec_data_pkg::vreg_idx_t vreg,
	input  logic                    fill_en,
	input  vec_data_pkg::data_t     scalar,
	input  logic                    read_en,
	input  vec_data_pkg::address_t  elem_idx,
	input  logic                    st_start,
	input  logic                    ld_start,
	input  logic                    st_rd,
	input  logic                    ld_wr,
	input  vec_data_pkg::data_t     ld_data,
	output vec_data_pkg::data_t     st_data,
	output vec_data_pkg::data_t     result
);

	localparam int IW = $clog2(VLEN);

	vec_data_pkg::data_t regs [vec_data_pkg::NUM_VREGS][VLEN];
	logic [IW-1:0]       st_idx;	// Next element to store
	logic [IW-1:0]       ld_idx;	// Next element to load

	assign st_data = regs[vreg][st_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			st_idx <= '0;
			ld_idx <= '0;
		end else begin
			if (st_start) st_idx <= '0;
			else if (st_rd) st_idx <= st_idx + 1'b1;
			if (ld_start) ld_idx <= '0;
			else if (ld_wr) ld_idx <= ld_idx + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_en) begin
			for (int i = 0; i < VLEN; i++) regs[vreg][i] <= scalar;	// Broadcast
		end else if (ld_wr) begin
			regs[vreg][ld_idx] <= ld_data;
		end
	end

	always_ff @(posedge clock) begin
		if (read_en) result <= regs[vreg][elem_idx[IW-1:0]];	// Held until next read
	end

endmodule

// File: src/vec_lsu_top.sv
`timescale 1ns/1ns

module vec_lsu_top #(
	parameter int VLEN      = 16,
	parameter int MEM_DEPTH = 256
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  cmd_req,
	input  vec_cmd_pkg::vec_cmd_t cmd,
	input  logic                  mem_stall,
	output logic                  cmd_ack,
	output vec_data_pkg::data_t   cmd_result
);

	vec_cmd_pkg::mem_cfg_t    dec_cfg;
	vec_cmd_pkg::mem_cfg_t    lsu_cfg;
	vec_cmd_pkg::mem_req_t    mem_req;
	vec_cmd_pkg::mem_status_t mem_status;
	vec_data_pkg::vreg_idx_t  vreg;
	vec_data_pkg::data_t      scalar;
	vec_data_pkg::data_t      rf_st_data;
	vec_data_pkg::data_t      lsu_st_data;
	vec_data_pkg::data_t      mem_rdata;
	vec_data_pkg::data_t      lsu_ld_data;
	vec_data_pkg::address_t   elem_idx;
	vec_data_pkg::address_t   mem_addr;
	logic st_start, ld_start, st_done, ld_done;
	logic fill_en, read_en, st_rd_rf, ld_wr_rf, run;
	logic st_ready, ld_ready, st_end, ld_end;

	assign mem_status = '{st_ready: st_ready, ld_ready: ld_ready, st_end: st_end, ld_end: ld_end};

	vec_cmd_decoder vec_cmd_decoder_i (
		.clock, .reset, .cmd_req, .cmd, .st_done, .ld_done, .cmd_ack, .st_start, .ld_start,
		.cfg(dec_cfg), .vreg, .fill_en, .read_en, .scalar, .elem_idx
	);

	load_store_unit load_store_unit_i (
		.clock, .reset, .st_start, .ld_start, .cfg(dec_cfg), .stall(mem_stall),
		.status(mem_status), .st_data_rf(rf_st_data), .ld_data_mem(mem_rdata), .req(mem_req),
		.run, .cfg_out(lsu_cfg), .st_rd_rf, .ld_wr_rf, .st_data(lsu_st_data),
		.ld_data(lsu_ld_data), .st_done, .ld_done
	);

	stride_addr_gen #(.MEM_DEPTH(MEM_DEPTH)) stride_addr_gen_i (
		.clock, .reset, .run, .cfg(lsu_cfg), .req(mem_req), .advance(mem_req.valid),
		.addr(mem_addr), .st_end, .ld_end
	);

	local_data_mem #(.MEM_DEPTH(MEM_DEPTH)) local_data_mem_i (
		.clock, .reset, .addr(mem_addr), .req(mem_req), .stall(mem_stall),
		.wdata(lsu_st_data), .rdata(mem_rdata), .st_ready, .ld_ready
	);

	vector_reg_file #(.VLEN(VLEN)) vector_reg_file_i (
		.clock, .reset, .vreg, .fill_en, .scalar, .read_en, .elem_idx, .st_start, .ld_start,
		.st_rd(st_rd_rf), .ld_wr(ld_wr_rf), .ld_data(lsu_ld_data), .st_data(rf_st_data),
		.result(cmd_result)
	);

endmodule

// File: tests/tb_vec_lsu.sv
`timescale 1ns/1ns

module tb_vec_lsu;

	localparam int VLEN       = 16;
	localparam int MEM_DEPTH  = 256;
	localparam int MAX_CYCLES = 4000;	// About 1300 worst-case command cycles, times three

	logic                  clock;
	logic                  reset;
	logic                  cmd_req;
	vec_cmd_pkg::vec_cmd_t cmd;
	logic                  mem_stall;
	logic                  cmd_ack;
	vec_data_pkg::data_t   cmd_result;

	vec_data_pkg::data_t model_vregs [vec_data_pkg::NUM_VREGS][VLEN];	// Shadow registers
	vec_data_pkg::data_t model_mem [MEM_DEPTH];	// Shadow memory
	vec_data_pkg::data_t readback [$];	// Read results of the strided runs
	vec_data_pkg::data_t pattern [3];
	logic [31:0]         rand_state;
	logic                stall_mode;	// Random mem_stall while high
	int                  cycle_count;

	vec_lsu_top #(.VLEN(VLEN), .MEM_DEPTH(MEM_DEPTH)) vec_lsu_top_i (
		.clock, .reset, .cmd_req, .cmd, .mem_stall, .cmd_ack, .cmd_result
	);

	always #4 clock = ~clock;

	task automatic fail_run();
		$display("Errors found");
		$fatal(1);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, a command did not complete", MAX_CYCLES);
			fail_run();
		end
	end

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Element i of a strided access, wrapped to the memory depth
	function automatic int mem_index(input int base, input int stride, input int i);
		return (base + i * stride) % MEM_DEPTH;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			fail_run();
		end
	endtask

	// Updates the model, runs one four-phase handshake and checks it
	task automatic issue_command(input vec_cmd_pkg::opcode_e op, input int vreg, input int base,
			input int stride, input int length, input vec_data_pkg::data_t scalar,
			input int hold, output vec_data_pkg::data_t result);
		vec_cmd_pkg::vec_cmd_t c;
		logic [31:0]           rnd;
		int                    fall_cycles;
		c.opcode = op;
		c.vreg   = vec_data_pkg::vreg_idx_t'(vreg);
		c.base   = vec_data_pkg::address_t'(base);	// Element index for reads
		c.stride = vec_data_pkg::address_t'(stride);
		c.length = vec_data_pkg::address_t'(length);
		c.scalar = scalar;
		case (op)
			vec_cmd_pkg::OP_FILL:
				for (int i = 0; i < VLEN; i++) model_vregs[vreg][i] = scalar;
			vec_cmd_pkg::OP_STORE:
				for (int i = 0; i < length; i++)
					model_mem[mem_index(base, stride, i)] = model_vregs[vreg][i];
			vec_cmd_pkg::OP_LOAD:
				for (int i = 0; i < length; i++)
					model_vregs[vreg][i] = model_mem[mem_index(base, stride, i)];
			default: ;
		endcase
		@(posedge clock);
		cmd     <= c;
		cmd_req <= 1'b1;
		do begin
			@(posedge clock);
			rnd = next_random();
			mem_stall <= stall_mode & rnd[31];
			@(negedge clock);
		end while (!cmd_ack);
		result = cmd_result;
		if (op == vec_cmd_pkg::OP_READ)
			check_value($sformatf("cmd_result v%0d[%0d]", vreg, base), cmd_result,
				model_vregs[vreg][base]);
		repeat (hold) begin
			@(negedge clock);
			check_value("cmd_ack while cmd_req high", 32'(cmd_ack), 32'd1);
		end
		@(posedge clock);
		cmd_req   <= 1'b0;
		mem_stall <= 1'b0;
		fall_cycles = 0;
		do begin
			@(negedge clock);
			fall_cycles++;
		end while (cmd_ack);
		check_value("cycles from cmd_req drop to cmd_ack drop", 32'(fall_cycles), 32'd2);
	endtask

	task automatic fill_reg(input int vreg, input vec_data_pkg::data_t scalar);
		vec_data_pkg::data_t ignored;
		issue_command(vec_cmd_pkg::OP_FILL, vreg, 0, 0, 0, scalar, 0, ignored);
	endtask

	task automatic mem_access(input vec_cmd_pkg::opcode_e op, input int vreg, input int base,
			input int stride, input int length);
		vec_data_pkg::data_t ignored;
		issue_command(op, vreg, base, stride, length, '0, 0, ignored);
	endtask

	task automatic read_all_elements(input int vreg);
		vec_data_pkg::data_t value;
		for (int i = 0; i < VLEN; i++) begin
			issue_command(vec_cmd_pkg::OP_READ, vreg, i, 0, 0, '0, 0, value);
			readback.push_back(value);
		end
	endtask

	task automatic fill_and_read_back();
		fill_reg(0, next_random());
		read_all_elements(0);
	endtask

	task automatic store_then_load();
		fill_reg(0, next_random());
		fill_reg(1, next_random());	// Old v1 contents must be replaced
		mem_access(vec_cmd_pkg::OP_STORE, 0, 10, 1, VLEN);
		mem_access(vec_cmd_pkg::OP_LOAD, 1, 10, 1, VLEN);
		read_all_elements(1);
	endtask

	// Three interleaved stride-3 stores from 250 cover 250..255 and 0..41
	task automatic strided_wrap_transfers(input logic stalled);
		stall_mode = stalled;
		readback.delete();
		for (int k = 0; k < 3; k++) begin
			fill_reg(2, pattern[k]);
			mem_access(vec_cmd_pkg::OP_STORE, 2, 250 + k, 3, VLEN);
		end
		mem_access(vec_cmd_pkg::OP_LOAD, 3, 250, 1, VLEN);
		mem_access(vec_cmd_pkg::OP_LOAD, 1, 254, 2, VLEN);
		read_all_elements(3);
		read_all_elements(1);
		stall_mode = 1'b0;
	endtask

	task automatic stalled_transfers();
		vec_data_pkg::data_t unstalled [$];
		vec_data_pkg::data_t scrub;
		unstalled = readback;
		// Registers and the strided region hold other data before the stalled run
		scrub = next_random();
		fill_reg(1, scrub);
		fill_reg(2, scrub);
		fill_reg(3, scrub);
		for (int k = 0; k < 3; k++)
			mem_access(vec_cmd_pkg::OP_STORE, 2, 250 + 16 * k, 1, VLEN);
		strided_wrap_transfers(1'b1);
		foreach (unstalled[i])
			check_value($sformatf("stalled readback[%0d]", i), readback[i], unstalled[i]);
	endtask

	task automatic handshake_and_partial();
		vec_data_pkg::data_t ignored;
		fill_reg(0, next_random());
		mem_access(vec_cmd_pkg::OP_STORE, 0, 100, 1, VLEN);
		issue_command(vec_cmd_pkg::OP_FILL, 1, 0, 0, 0, next_random(), 3, ignored);
		issue_command(vec_cmd_pkg::OP_LOAD, 1, 100, 1, 1, '0, 3, ignored);	// Only element 0
		read_all_elements(1);
		fill_reg(1, next_random());
		mem_access(vec_cmd_pkg::OP_LOAD, 1, 100, 1, 5);	// Elements 5 and up untouched
		read_all_elements(1);
	endtask

	initial begin
		clock       = 1'b0;
		reset       = 1'b1;
		cmd_req     = 1'b0;
		cmd         = '0;
		mem_stall   = 1'b0;
		stall_mode  = 1'b0;
		cycle_count = 0;
		rand_state  = 32'd48;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("cmd_ack after reset", 32'(cmd_ack), 32'd0);
		for (int k = 0; k < 3; k++) pattern[k] = next_random();
		fill_and_read_back();
		store_then_load();
		strided_wrap_transfers(1'b0);
		stalled_transfers();
		handshake_and_partial();
		$display("No errors");
		$finish;
	end

endmodule

// File: vlog.f
src/vec_data_pkg.sv
src/vec_cmd_pkg.sv
src/vec_cmd_decoder.sv
src/load_store_unit.sv
src/stride_addr_gen.sv
src/local_data_mem.sv
src/vector_reg_file.sv
src/vec_lsu_top.sv
tests/tb_vec_lsu.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vec_lsu \
		-Mdir obj_dir -f vlog.f

run: compile
	-./obj_dir/Vtb_vec_lsu > sim.log 2>&1
	cat sim.log
	@if grep -q "Errors found" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log
